/* common/decode_pkg.sv */
// shared constants, opcode names and records of the decode stage
package decode_pkg;

  // data and pc width
  localparam int xlen = 32;

  // one name per 5-bit opcode value
  typedef enum logic [4:0] {
    op_alu_reg   = 5'd0,
    op_alu_imm   = 5'd1,
    op_lui       = 5'd2,
    // memory opcodes, word / half / byte
    op_mem_w_abs = 5'd3,
    op_mem_w_rel = 5'd4,
    op_mem_w_pcr = 5'd5,
    op_mem_h_abs = 5'd6,
    op_mem_h_rel = 5'd7,
    op_mem_h_pcr = 5'd8,
    op_mem_b_abs = 5'd9,
    op_mem_b_rel = 5'd10,
    op_mem_b_pcr = 5'd11,
    op_jmp       = 5'd12,
    op_br_abs    = 5'd13,
    op_br_rel    = 5'd14,
    op_syscall   = 5'd15,
    // atomics, cracked locally in decode
    op_fadd_abs  = 5'd16,
    op_fadd_rel  = 5'd17,
    op_fadd_imm  = 5'd18,
    op_swap_abs  = 5'd19,
    op_swap_rel  = 5'd20,
    op_swap_imm  = 5'd21,
    op_adpc      = 5'd22,
    op_rsv_23    = 5'd23,
    op_rsv_24    = 5'd24,
    op_rsv_25    = 5'd25,
    op_rsv_26    = 5'd26,
    op_rsv_27    = 5'd27,
    op_rsv_28    = 5'd28,
    op_rsv_29    = 5'd29,
    op_rsv_30    = 5'd30,
    op_priv      = 5'd31
  } opcode_t;

  localparam logic [7:0] exc_invalid = 8'h80;
  localparam logic [7:0] exc_priv = 8'h81;
  // interrupt n reports as exc_irq_base + n
  localparam logic [7:0] exc_irq_base = 8'hF0;

  localparam logic [4:0] alu_add = 5'd14;

  typedef struct packed {
    logic [xlen-1:0] instr;
    logic [xlen-1:0] pc;
    logic            bubble;
    logic [7:0]      exc;
  } fetch_pkt_t;

  typedef struct packed {
    logic            we;
    logic [4:0]      target;
    logic [xlen-1:0] data;
  } wb_port_t;

  typedef struct packed {
    opcode_t         opcode;
    logic [4:0]      alu_op;
    logic [4:0]      s_1;
    logic [4:0]      s_2;
    logic [4:0]      tgt_1;
    logic [4:0]      tgt_2;
    logic [xlen-1:0] imm;
    logic [4:0]      branch_code;
    logic            is_load;
    logic            is_store;
    logic            is_branch;
    logic            is_post_inc;
    logic            tgts_cr;
    logic [4:0]      priv_type;
    logic [1:0]      crmov_mode;
    logic            is_atomic;
    logic            is_fetch_add;
    logic [1:0]      atomic_step;
    logic            writes_tgt_1;
  } uop_t;

  typedef struct packed {
    logic valid;
    logic reserved;
    logic is_alu;
    logic is_mem;
    logic is_branch;
    logic is_syscall;
    logic is_priv;
    logic is_fetch_add;
    logic is_swap;
  } instr_class_t;

endpackage

/* hdl/instr_decoder.sv */
`timescale 1ns/10ps

module instr_decoder (
  input  logic [decode_pkg::xlen-1:0] instr,
  input  logic                        kmode,
  output decode_pkg::instr_class_t    cls,
  output decode_pkg::uop_t            base,
  output logic [7:0]                  exc_code
);

  logic                        known;
  logic                        invalid;
  logic [decode_pkg::xlen-1:0] w;
  logic [4:0]                  opc;
  logic                        br_reg;
  logic                        is_abs;
  logic                        is_rel;
  logic                        is_pcr;
  logic                        load_bit;
  logic [4:0]                  r_a;
  logic [4:0]                  r_b;
  logic [4:0]                  alu_op;
  logic [4:0]                  priv_type;
  logic [decode_pkg::xlen-1:0] imm;

  always_comb begin
    cls = '0;
    known = 1'b1;
    case (instr[31:27])
      5'd0, 5'd1: cls.is_alu = 1'b1;
      5'd2, 5'd22: known = 1'b1;
      5'd3, 5'd4, 5'd5, 5'd6, 5'd7, 5'd8, 5'd9, 5'd10, 5'd11: cls.is_mem = 1'b1;
      5'd12, 5'd13, 5'd14: cls.is_branch = 1'b1;
      5'd15: cls.is_syscall = 1'b1;
      5'd16, 5'd17, 5'd18: cls.is_fetch_add = 1'b1;
      5'd19, 5'd20, 5'd21: cls.is_swap = 1'b1;
      5'd23, 5'd24, 5'd25, 5'd26, 5'd27, 5'd28, 5'd29, 5'd30: cls.reserved = 1'b1;
      5'd31: cls.is_priv = 1'b1;
      // an unknown word decodes as all zero
      default: known = 1'b0;
    endcase

    w = known ? instr : '0;
    opc = w[31:27];
    br_reg = (opc == decode_pkg::op_br_abs) || (opc == decode_pkg::op_br_rel);
    is_abs = opc inside {5'd3, 5'd6, 5'd9};
    is_rel = opc inside {5'd4, 5'd7, 5'd10};
    is_pcr = opc inside {5'd5, 5'd8, 5'd11};

    // register branches keep their operands in the low bits
    r_a = br_reg ? w[9:5] : w[26:22];
    r_b = br_reg ? w[4:0] : w[21:17];
    alu_op = (opc == decode_pkg::op_alu_reg) ? w[9:5] : w[16:12];
    priv_type = w[16:12];
    // load/store select moves up for pc-relative forms
    load_bit = is_pcr ? w[21] : w[16];

    invalid = cls.reserved ||
              ((opc == decode_pkg::op_alu_imm) && (alu_op > 5'd18)) ||
              ((opc == decode_pkg::op_alu_reg) && (alu_op > 5'd22)) ||
              (cls.is_branch && (w[26:22] > 5'd18)) ||
              (cls.is_syscall && (w[7:0] != 8'd1)) ||
              (cls.is_priv && (priv_type > 5'd3));
    cls.valid = known && !invalid;

    if (invalid) begin
      exc_code = decode_pkg::exc_invalid;
    end else if (cls.is_priv && !kmode) begin
      exc_code = decode_pkg::exc_priv;
    end else if (cls.is_syscall) begin
      exc_code = w[7:0];
    end else begin
      exc_code = 8'h00;
    end

    // immediate by opcode and alu range
    imm = '0;
    if ((opc == decode_pkg::op_alu_imm) && (alu_op <= 5'd6)) begin
      imm = {24'b0, w[7:0]} << {w[9:8], 3'b000};
    end else if ((opc == decode_pkg::op_alu_imm) && (alu_op <= 5'd13)) begin
      imm = {27'b0, w[4:0]};
    end else if (opc == decode_pkg::op_alu_imm) begin
      imm = {{20{w[11]}}, w[11:0]};
    end else if (opc == decode_pkg::op_lui) begin
      imm = {w[21:0], 10'b0};
    end else if ((opc == decode_pkg::op_jmp) || (opc == decode_pkg::op_adpc)) begin
      imm = {{10{w[21]}}, w[21:0]};
    end else if (is_abs) begin
      imm = {{20{w[11]}}, w[11:0]} << w[13:12];
    end else if (is_rel) begin
      imm = {{16{w[15]}}, w[15:0]};
    end else if (is_pcr) begin
      imm = {{11{w[20]}}, w[20:0]};
    end

    base = '0;
    base.opcode = decode_pkg::opcode_t'(opc);
    base.alu_op = alu_op;
    // lui, pc-relative, jmp, syscall and alu op 6 take no first source
    if ((opc == decode_pkg::op_lui) || is_pcr || (opc == decode_pkg::op_jmp) ||
        (opc == decode_pkg::op_syscall) || (cls.is_alu && (alu_op == 5'd6))) begin
      base.s_1 = 5'd0;
    end else begin
      base.s_1 = r_b;
    end
    // stores and priv read r_a, alu_reg reads r_c
    if ((cls.is_mem && !load_bit) || cls.is_priv) begin
      base.s_2 = r_a;
    end else if (opc == decode_pkg::op_alu_reg) begin
      base.s_2 = w[4:0];
    end
    base.tgt_1 = r_a;
    // pre/post increment writes the base register back
    base.tgt_2 = (is_abs && (w[15:14] != 2'd0)) ? r_b : 5'd0;
    base.imm = imm;
    base.branch_code = w[26:22];
    base.is_load = cls.is_mem && load_bit;
    base.is_store = cls.is_mem && !load_bit;
    base.is_branch = cls.is_branch;
    base.is_post_inc = is_abs && (w[15:14] == 2'd2);
    base.tgts_cr = cls.is_priv && (priv_type == 5'd1) && !w[10];
    base.priv_type = cls.is_priv ? priv_type : 5'd0;
    base.crmov_mode = cls.is_priv ? w[11:10] : 2'd0;
    if ((opc == decode_pkg::op_jmp) || (opc == decode_pkg::op_syscall)) begin
      base.writes_tgt_1 = 1'b0;
    end else if (cls.is_priv) begin
      // crmv always names a target, tlbr writes a gpr
      base.writes_tgt_1 = (priv_type == 5'd1) ||
                          ((priv_type == 5'd0) && (w[11:10] == 2'd0));
    end else begin
      base.writes_tgt_1 = !base.is_store;
    end
  end

endmodule

/* hdl/atomic_cracker.sv */
`timescale 1ns/10ps

module atomic_cracker (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        stall,
  input  logic                        flush,
  input  decode_pkg::fetch_pkt_t      front,
  input  decode_pkg::uop_t            base,
  output logic [decode_pkg::xlen-1:0] cur_instr,
  output logic [decode_pkg::xlen-1:0] cur_pc,
  output decode_pkg::uop_t            uop_out,
  output logic                        decode_stall
);

  logic                        active;
  logic                        is_fadd;
  logic [1:0]                  step;
  logic [decode_pkg::xlen-1:0] instr_q;
  logic [decode_pkg::xlen-1:0] pc_q;
  logic                        front_fadd;
  logic                        front_swap;
  logic                        inflight;
  logic                        mode;
  logic [1:0]                  step_cur;
  logic                        last;
  logic                        imm_form;
  logic                        rel_form;
  decode_pkg::opcode_t         mem_op;
  logic [4:0]                  base_reg;
  logic [decode_pkg::xlen-1:0] atom_imm;

  assign front_fadd = front.instr[31:27] inside {5'd16, 5'd17, 5'd18};
  assign front_swap = front.instr[31:27] inside {5'd19, 5'd20, 5'd21};

  // a faulting or dead slot never starts a sequence
  assign inflight = active ||
                    ((front_fadd || front_swap) && !flush && !front.bubble && (front.exc == 8'h00));
  assign mode = active ? is_fadd : front_fadd;
  assign step_cur = active ? step : 2'd0;
  assign last = mode ? (step_cur == 2'd2) : (step_cur == 2'd1);
  // fetch may advance once the final step is on its way out
  assign decode_stall = inflight && !last;

  assign cur_instr = active ? instr_q : front.instr;
  assign cur_pc = active ? pc_q : front.pc;

  assign imm_form = (base.opcode == decode_pkg::op_fadd_imm) ||
                    (base.opcode == decode_pkg::op_swap_imm);
  assign rel_form = (base.opcode == decode_pkg::op_fadd_rel) ||
                    (base.opcode == decode_pkg::op_swap_rel);
  assign mem_op = imm_form ? decode_pkg::op_mem_w_pcr :
                  (rel_form ? decode_pkg::op_mem_w_rel : decode_pkg::op_mem_w_abs);
  assign base_reg = imm_form ? 5'd0 : cur_instr[16:12];
  assign atom_imm = imm_form ? {{15{cur_instr[16]}}, cur_instr[16:0]} :
                               {{20{cur_instr[11]}}, cur_instr[11:0]};

  always_comb begin
    uop_out = base;
    if (inflight) begin
      uop_out.opcode = mem_op;
      uop_out.s_1 = base_reg;
      uop_out.s_2 = cur_instr[21:17];
      uop_out.tgt_2 = 5'd0;
      uop_out.imm = atom_imm;
      uop_out.is_load = (step_cur == 2'd0);
      uop_out.is_store = last;
      uop_out.is_branch = 1'b0;
      uop_out.is_post_inc = 1'b0;
      uop_out.tgts_cr = 1'b0;
      uop_out.is_atomic = 1'b1;
      uop_out.is_fetch_add = mode;
      uop_out.atomic_step = step_cur;
      uop_out.writes_tgt_1 = !last;
      // middle fetch-add step adds data to r_a
      if (mode && (step_cur == 2'd1)) begin
        uop_out.opcode = decode_pkg::op_alu_reg;
        uop_out.alu_op = decode_pkg::alu_add;
        uop_out.s_1 = cur_instr[21:17];
        uop_out.s_2 = base.tgt_1;
        uop_out.imm = '0;
      end
      if (mode && last) begin
        uop_out.s_2 = base.tgt_1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      active <= 1'b0;
      is_fadd <= 1'b0;
      step <= 2'd0;
    end else if (!stall) begin
      if (flush || front.bubble) begin
        active <= 1'b0;
        step <= 2'd0;
      end else if (inflight && !last) begin
        active <= 1'b1;
        is_fadd <= mode;
        step <= step_cur + 2'd1;
      end else begin
        active <= 1'b0;
        step <= 2'd0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!stall && !active) begin
      instr_q <= front.instr;
      pc_q <= front.pc;
    end
  end

  // step 0 is the entry cycle, so a live swap only ever sits in step 1
  a_step_range: assert property (@(posedge clk) disable iff (rst)
    active |-> (step != 2'd3) && (is_fadd || (step == 2'd1)));

endmodule

/* hdl/gpr_file.sv */
`timescale 1ns/10ps

module gpr_file (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        stall,
  input  logic [4:0]                  s_1,
  input  logic [4:0]                  s_2,
  input  decode_pkg::wb_port_t        wb_1,
  input  decode_pkg::wb_port_t        wb_2,
  output logic [decode_pkg::xlen-1:0] d_1,
  output logic [decode_pkg::xlen-1:0] d_2,
  output logic [decode_pkg::xlen-1:0] ret_val
);

  logic [decode_pkg::xlen-1:0] regs [32];

  // same-cycle write-back bypass, wb_2 ahead of wb_1
  function automatic logic [decode_pkg::xlen-1:0] read_fwd(input logic [4:0] a);
    if (a == 5'd0) begin
      return '0;
    end else if (wb_2.we && (wb_2.target == a)) begin
      return wb_2.data;
    end else if (wb_1.we && (wb_1.target == a)) begin
      return wb_1.data;
    end
    return regs[a];
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (wb_1.we && (wb_1.target != 5'd0)) begin
        regs[wb_1.target] <= wb_1.data;
      end
      // later write takes the collision
      if (wb_2.we && (wb_2.target != 5'd0)) begin
        regs[wb_2.target] <= wb_2.data;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      d_1 <= read_fwd(s_1);
      d_2 <= read_fwd(s_2);
    end
  end

  assign ret_val = regs[1];

  a_r0_zero: assert property (@(posedge clk) disable iff (rst)
    (!stall && (s_1 == 5'd0)) |=> (d_1 == '0));

endmodule

/* hdl/decode_stage.sv */
`timescale 1ns/10ps

module decode_stage (
  input  logic                        clk,
  input  logic                        rst,
  input  decode_pkg::fetch_pkt_t      fetch,
  input  decode_pkg::wb_port_t        wb_1,
  input  decode_pkg::wb_port_t        wb_2,
  input  logic                        stall,
  input  logic                        flush,
  input  logic                        kmode,
  input  logic [15:0]                 interrupts,
  output decode_pkg::uop_t            uop,
  output logic [decode_pkg::xlen-1:0] pc_out,
  output logic [decode_pkg::xlen-1:0] d_1,
  output logic [decode_pkg::xlen-1:0] d_2,
  output logic [decode_pkg::xlen-1:0] ret_val,
  output logic                        bubble_out,
  output logic [7:0]                  exc_out,
  output logic                        decode_stall
);

  logic [decode_pkg::xlen-1:0] cur_instr;
  logic [decode_pkg::xlen-1:0] cur_pc;
  decode_pkg::uop_t            base;
  decode_pkg::uop_t            cracked;
  decode_pkg::uop_t            live;
  logic [7:0]                  dec_exc;
  logic [7:0]                  irq_exc;
  logic [7:0]                  exc_sel;
  logic                        kill;
  logic                        slot_kill;

  atomic_cracker i_cracker (
    .clk          (clk),
    .rst          (rst),
    .stall        (stall),
    .flush        (flush),
    .front        (fetch),
    .base         (base),
    .cur_instr    (cur_instr),
    .cur_pc       (cur_pc),
    .uop_out      (cracked),
    .decode_stall (decode_stall)
  );

  instr_decoder i_decoder (
    .instr    (cur_instr),
    .kmode    (kmode),
    .cls      (),
    .base     (base),
    .exc_code (dec_exc)
  );

  gpr_file i_gpr (
    .clk     (clk),
    .rst     (rst),
    .stall   (stall),
    .s_1     (cracked.s_1),
    .s_2     (cracked.s_2),
    .wb_1    (wb_1),
    .wb_2    (wb_2),
    .d_1     (d_1),
    .d_2     (d_2),
    .ret_val (ret_val)
  );

  // highest pending line wins
  always_comb begin
    irq_exc = 8'h00;
    for (int i = 0; i < 16; i++) begin
      if (interrupts[i]) begin
        irq_exc = decode_pkg::exc_irq_base + 8'(i);
      end
    end
  end

  assign exc_sel = (irq_exc != 8'h00) ? irq_exc :
                   ((fetch.exc != 8'h00) ? fetch.exc : dec_exc);
  assign kill = flush || fetch.bubble;
  assign slot_kill = kill || (exc_sel != 8'h00);

  always_comb begin
    live = cracked;
    // no destination means nothing for execute to forward from
    if (!cracked.writes_tgt_1) begin
      live.tgt_1 = 5'd0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      uop <= '0;
      bubble_out <= 1'b1;
      exc_out <= 8'h00;
    end else if (!stall) begin
      uop <= slot_kill ? '0 : live;
      // a pending interrupt keeps even a killed slot live
      bubble_out <= kill && (irq_exc == 8'h00);
      exc_out <= kill ? irq_exc : exc_sel;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      pc_out <= cur_pc;
    end
  end

  a_exc_live: assert property (@(posedge clk) disable iff (rst)
    (exc_out != 8'h00) |-> !bubble_out && (uop == '0));

endmodule

/* sim/tb_decode_stage.sv */
`timescale 1ns/10ps

module tb_decode_stage;

  // one table row, stimulus first and expected registered outputs after
  typedef struct packed {
    decode_pkg::fetch_pkt_t fetch;
    logic                   stall;
    logic                   flush;
    logic                   kmode;
    logic [15:0]            irq;
    decode_pkg::wb_port_t   wb_1;
    decode_pkg::wb_port_t   wb_2;
    logic [4:0]             exp_opcode;
    logic [4:0]             exp_alu;
    logic                   chk_alu;
    logic [31:0]            exp_imm;
    logic [4:0]             exp_tgt_1;
    logic [1:0]             exp_step;
    logic                   exp_bubble;
    logic [7:0]             exp_exc;
    logic                   exp_stall;
    logic [31:0]            exp_d_1;
    logic [31:0]            exp_d_2;
    logic [31:0]            exp_ret;
  } row_t;

  logic                   clk = 1'b0;
  logic                   rst;
  decode_pkg::fetch_pkt_t fetch;
  decode_pkg::wb_port_t   wb_1;
  decode_pkg::wb_port_t   wb_2;
  logic                   stall;
  logic                   flush;
  logic                   kmode;
  logic [15:0]            interrupts;
  decode_pkg::uop_t       uop;
  logic [31:0]            pc_out;
  logic [31:0]            d_1;
  logic [31:0]            d_2;
  logic [31:0]            ret_val;
  logic                   bubble_out;
  logic [7:0]             exc_out;
  logic                   decode_stall;

  row_t        rows[$];
  row_t        cur;
  logic [31:0] rand_a;
  logic [31:0] rand_b;
  logic [31:0] rand_c;
  logic [31:0] rand_d;
  logic [31:0] r1_val;
  int          cycles = 0;

  decode_stage i_dut (
    .clk          (clk),
    .rst          (rst),
    .fetch        (fetch),
    .wb_1         (wb_1),
    .wb_2         (wb_2),
    .stall        (stall),
    .flush        (flush),
    .kmode        (kmode),
    .interrupts   (interrupts),
    .uop          (uop),
    .pc_out       (pc_out),
    .d_1          (d_1),
    .d_2          (d_2),
    .ret_val      (ret_val),
    .bubble_out   (bubble_out),
    .exc_out      (exc_out),
    .decode_stall (decode_stall)
  );

  always #2 clk = ~clk;

  // every row needs at most two cycles, plus reset and drain
  always @(posedge clk) begin
    cycles = cycles + 1;
    if ((rows.size() > 0) && (cycles > 2 * rows.size() + 20)) begin
      $display("timeout: table did not finish");
      $display("Simulation FAILED");
      $fatal(1, "cycle limit reached");
    end
  end

  function automatic logic [31:0] word(input logic [4:0] op, input logic [4:0] ra,
                                       input logic [4:0] rb, input logic [16:0] low);
    return {op, ra, rb, low};
  endfunction

  task automatic set_stim(input logic [31:0] instr, input logic bubble,
                          input logic [7:0] fexc, input logic flsh, input logic kmd,
                          input logic [15:0] irq);
    cur = '0;
    cur.fetch.instr = instr;
    cur.fetch.pc = 32'h0000_1000 + 4 * rows.size();
    cur.fetch.bubble = bubble;
    cur.fetch.exc = fexc;
    cur.flush = flsh;
    cur.kmode = kmd;
    cur.irq = irq;
  endtask

  task automatic plain(input logic [31:0] instr);
    set_stim(instr, 1'b0, 8'h00, 1'b0, 1'b1, 16'h0000);
  endtask

  // fetch keeps the same packet while decode holds it
  task automatic hold_fetch(input logic stl, input logic flsh);
    cur = '0;
    cur.fetch = rows[rows.size() - 1].fetch;
    cur.stall = stl;
    cur.flush = flsh;
    cur.kmode = 1'b1;
  endtask

  task automatic set_wb(input decode_pkg::wb_port_t w1, input decode_pkg::wb_port_t w2);
    cur.wb_1 = w1;
    cur.wb_2 = w2;
    // register 1 as it reads after this row, the second port landing last
    if (w1.we && (w1.target == 5'd1)) begin
      r1_val = w1.data;
    end
    if (w2.we && (w2.target == 5'd1)) begin
      r1_val = w2.data;
    end
  endtask

  task automatic expect_alu(input logic [4:0] v);
    cur.exp_alu = v;
    cur.chk_alu = 1'b1;
  endtask

  task automatic expect_step(input logic [1:0] s);
    cur.exp_step = s;
  endtask

  task automatic expect_d_2(input logic [31:0] v);
    cur.exp_d_2 = v;
  endtask

  task automatic push_expect(input logic [4:0] op, input logic [31:0] imm,
                             input logic [4:0] tgt, input logic bub, input logic [7:0] exc,
                             input logic ds, input logic [31:0] d1);
    cur.exp_opcode = op;
    cur.exp_imm = imm;
    cur.exp_tgt_1 = tgt;
    cur.exp_bubble = bub;
    cur.exp_exc = exc;
    cur.exp_stall = ds;
    cur.exp_d_1 = d1;
    cur.exp_ret = r1_val;
    rows.push_back(cur);
  endtask

  // a stalled row expects the previous outputs to hold
  task automatic push_hold(input logic ds);
    row_t prev;
    prev = rows[rows.size() - 1];
    cur.exp_opcode = prev.exp_opcode;
    cur.exp_alu = prev.exp_alu;
    cur.chk_alu = prev.chk_alu;
    cur.exp_imm = prev.exp_imm;
    cur.exp_tgt_1 = prev.exp_tgt_1;
    cur.exp_step = prev.exp_step;
    cur.exp_bubble = prev.exp_bubble;
    cur.exp_exc = prev.exp_exc;
    cur.exp_d_1 = prev.exp_d_1;
    cur.exp_d_2 = prev.exp_d_2;
    cur.exp_ret = r1_val;
    cur.exp_stall = ds;
    rows.push_back(cur);
  endtask

  task automatic build_table();
    // immediates and field placement
    plain(word(decode_pkg::op_alu_imm, 5'd3, 5'd0, {5'd2, 4'b0010, 8'hA5}));
    expect_alu(5'd2);
    push_expect(5'd1, 32'h00A5_0000, 5'd3, 1'b0, 8'h00, 1'b0, 32'h0);
    plain(word(decode_pkg::op_alu_imm, 5'd4, 5'd0, {5'd9, 7'h55, 5'h1B}));
    expect_alu(5'd9);
    push_expect(5'd1, 32'h0000_001B, 5'd4, 1'b0, 8'h00, 1'b0, 32'h0);
    plain(word(decode_pkg::op_alu_imm, 5'd5, 5'd0, {5'd16, 12'h9C3}));
    expect_alu(5'd16);
    push_expect(5'd1, 32'hFFFF_F9C3, 5'd5, 1'b0, 8'h00, 1'b0, 32'h0);
    plain(word(decode_pkg::op_lui, 5'd6, 5'd0, 17'h12345));
    push_expect(5'd2, 32'h048D_1400, 5'd6, 1'b0, 8'h00, 1'b0, 32'h0);
    plain({decode_pkg::op_jmp, 5'd4, 22'h20_0010});
    push_expect(5'd12, 32'hFFE0_0010, 5'd0, 1'b0, 8'h00, 1'b0, 32'h0);
    plain(word(decode_pkg::op_mem_w_abs, 5'd7, 5'd0, {1'b1, 2'b00, 2'b10, 12'h804}));
    push_expect(5'd3, 32'hFFFF_E010, 5'd7, 1'b0, 8'h00, 1'b0, 32'h0);
    plain(word(decode_pkg::op_mem_w_rel, 5'd8, 5'd0, {1'b1, 16'h8001}));
    push_expect(5'd4, 32'hFFFF_8001, 5'd8, 1'b0, 8'h00, 1'b0, 32'h0);
    plain({decode_pkg::op_mem_w_pcr, 5'd9, 1'b1, 21'h10_0003});
    push_expect(5'd5, 32'hFFF0_0003, 5'd9, 1'b0, 8'h00, 1'b0, 32'h0);
    // write-back, r0, port priority and r1 on ret_val
    plain(word(decode_pkg::op_alu_imm, 5'd2, 5'd0, 17'h0));
    set_wb({1'b1, 5'd10, rand_a}, {1'b1, 5'd1, rand_b});
    push_expect(5'd1, 32'h0, 5'd2, 1'b0, 8'h00, 1'b0, 32'h0);
    plain(word(decode_pkg::op_alu_imm, 5'd2, 5'd10, 17'h0));
    push_expect(5'd1, 32'h0, 5'd2, 1'b0, 8'h00, 1'b0, rand_a);
    plain(word(decode_pkg::op_alu_imm, 5'd2, 5'd0, 17'h0));
    set_wb({1'b1, 5'd0, rand_b}, '0);
    push_expect(5'd1, 32'h0, 5'd2, 1'b0, 8'h00, 1'b0, 32'h0);
    plain(word(decode_pkg::op_alu_imm, 5'd2, 5'd11, 17'h0));
    set_wb({1'b1, 5'd11, rand_c}, {1'b1, 5'd11, rand_d});
    push_expect(5'd1, 32'h0, 5'd2, 1'b0, 8'h00, 1'b0, rand_d);
    plain(word(decode_pkg::op_alu_imm, 5'd2, 5'd11, 17'h0));
    push_expect(5'd1, 32'h0, 5'd2, 1'b0, 8'h00, 1'b0, rand_d);
    // decode exceptions
    plain(word(decode_pkg::op_rsv_23, 5'd0, 5'd0, 17'h0));
    push_expect(5'd0, 32'h0, 5'd0, 1'b0, 8'h80, 1'b0, 32'h0);
    set_stim(word(decode_pkg::op_priv, 5'd0, 5'd0, 17'h0), 1'b0, 8'h00, 1'b0, 1'b0, 16'h0);
    push_expect(5'd0, 32'h0, 5'd0, 1'b0, 8'h81, 1'b0, 32'h0);
    plain(word(decode_pkg::op_syscall, 5'd0, 5'd0, 17'h1));
    push_expect(5'd0, 32'h0, 5'd0, 1'b0, 8'h01, 1'b0, 32'h0);
    plain(word(decode_pkg::op_syscall, 5'd0, 5'd0, 17'h5));
    push_expect(5'd0, 32'h0, 5'd0, 1'b0, 8'h80, 1'b0, 32'h0);
    // interrupts ahead of a fetch fault
    set_stim(word(decode_pkg::op_alu_imm, 5'd2, 5'd0, 17'h0), 1'b0, 8'h22, 1'b0, 1'b1,
             16'h0208);
    push_expect(5'd0, 32'h0, 5'd0, 1'b0, 8'hF9, 1'b0, 32'h0);
    set_stim(word(decode_pkg::op_alu_imm, 5'd2, 5'd0, 17'h0), 1'b0, 8'h22, 1'b0, 1'b1,
             16'h0000);
    push_expect(5'd0, 32'h0, 5'd0, 1'b0, 8'h22, 1'b0, 32'h0);
    // fetch-add with a stall after the load step
    plain(word(decode_pkg::op_fadd_abs, 5'd12, 5'd11, {5'd10, 12'hFF0}));
    expect_d_2(rand_d);
    push_expect(5'd3, 32'hFFFF_FFF0, 5'd12, 1'b0, 8'h00, 1'b1, rand_a);
    hold_fetch(1'b1, 1'b0);
    push_hold(1'b1);
    hold_fetch(1'b0, 1'b0);
    expect_alu(5'd14);
    expect_step(2'd1);
    push_expect(5'd0, 32'h0, 5'd12, 1'b0, 8'h00, 1'b1, rand_d);
    hold_fetch(1'b0, 1'b0);
    expect_step(2'd2);
    push_expect(5'd3, 32'hFFFF_FFF0, 5'd0, 1'b0, 8'h00, 1'b0, rand_a);
    // swap in two steps
    plain(word(decode_pkg::op_swap_rel, 5'd13, 5'd10, {5'd11, 12'h07F}));
    expect_d_2(rand_a);
    push_expect(5'd4, 32'h0000_007F, 5'd13, 1'b0, 8'h00, 1'b1, rand_d);
    hold_fetch(1'b0, 1'b0);
    expect_d_2(rand_a);
    expect_step(2'd1);
    push_expect(5'd4, 32'h0000_007F, 5'd0, 1'b0, 8'h00, 1'b0, rand_d);
    // dead slots
    set_stim(word(decode_pkg::op_alu_imm, 5'd3, 5'd0, 17'h5), 1'b0, 8'h00, 1'b1, 1'b1, 16'h0);
    push_expect(5'd0, 32'h0, 5'd0, 1'b1, 8'h00, 1'b0, 32'h0);
    set_stim(word(decode_pkg::op_alu_imm, 5'd3, 5'd0, 17'h5), 1'b1, 8'h00, 1'b0, 1'b1, 16'h0);
    push_expect(5'd0, 32'h0, 5'd0, 1'b1, 8'h00, 1'b0, 32'h0);
    // flush cancels a fetch-add after its first step
    plain(word(decode_pkg::op_fadd_abs, 5'd14, 5'd10, {5'd10, 12'h010}));
    expect_d_2(rand_a);
    push_expect(5'd3, 32'h0000_0010, 5'd14, 1'b0, 8'h00, 1'b1, rand_a);
    hold_fetch(1'b0, 1'b1);
    push_expect(5'd0, 32'h0, 5'd0, 1'b1, 8'h00, 1'b1, rand_a);
    plain(word(decode_pkg::op_alu_imm, 5'd15, 5'd0, {5'd0, 12'h011}));
    push_expect(5'd1, 32'h0000_0011, 5'd15, 1'b0, 8'h00, 1'b0, 32'h0);
  endtask

  task automatic drive_row(input row_t r);
    fetch = r.fetch;
    stall = r.stall;
    flush = r.flush;
    kmode = r.kmode;
    interrupts = r.irq;
    wb_1 = r.wb_1;
    wb_2 = r.wb_2;
  endtask

  task automatic check_field(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      $display("Simulation FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic check_zero_uop();
    assert (uop == '0) else begin
      $display("** Error at %0t ns: uop is not all zero for a dead or faulting slot", $time);
      $display("Simulation FAILED");
      $fatal(1, "uop not cleared");
    end
  endtask

  task automatic check_outputs(input row_t r);
    check_field("opcode", 32'(uop.opcode), 32'(r.exp_opcode));
    if (r.chk_alu) begin
      check_field("alu_op", 32'(uop.alu_op), 32'(r.exp_alu));
    end
    check_field("imm", uop.imm, r.exp_imm);
    check_field("tgt_1", 32'(uop.tgt_1), 32'(r.exp_tgt_1));
    check_field("atomic_step", 32'(uop.atomic_step), 32'(r.exp_step));
    check_field("pc_out", pc_out, r.fetch.pc);
    check_field("bubble_out", 32'(bubble_out), 32'(r.exp_bubble));
    check_field("exc_out", 32'(exc_out), 32'(r.exp_exc));
    check_field("d_1", d_1, r.exp_d_1);
    check_field("d_2", d_2, r.exp_d_2);
    check_field("ret_val", ret_val, r.exp_ret);
    if (r.exp_bubble || (r.exp_exc != 8'h00)) begin
      check_zero_uop();
    end
  endtask

  initial begin
    rst = 1'b1;
    fetch = '0;
    fetch.bubble = 1'b1;
    wb_1 = '0;
    wb_2 = '0;
    stall = 1'b0;
    flush = 1'b0;
    kmode = 1'b0;
    interrupts = 16'h0000;
    r1_val = 32'h0;
    void'($urandom(32'h4706d4e2));
    rand_a = $urandom();
    rand_b = $urandom();
    rand_c = $urandom();
    rand_d = $urandom();
    build_table();

    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    check_field("bubble_out", 32'(bubble_out), 32'h1);
    check_field("exc_out", 32'(exc_out), 32'h0);
    check_field("decode_stall", 32'(decode_stall), 32'h0);
    check_zero_uop();

    // outputs of row i-1 are checked just before row i is driven
    for (int i = 0; i < rows.size(); i++) begin
      @(posedge clk);
      #1;
      if (i > 0) begin
        check_outputs(rows[i - 1]);
      end
      drive_row(rows[i]);
      #2;
      check_field("decode_stall", 32'(decode_stall), 32'(rows[i].exp_stall));
    end
    @(posedge clk);
    #1;
    check_outputs(rows[rows.size() - 1]);

    $display("Simulation PASSED");
    $finish;
  end

endmodule

/* src.f */
common/decode_pkg.sv
hdl/instr_decoder.sv
hdl/atomic_cracker.sv
hdl/gpr_file.sv
hdl/decode_stage.sv
sim/tb_decode_stage.sv

/* Makefile */
.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f src.f --top-module decode_stage

obj_dir/Vtb_decode_stage: src.f common/decode_pkg.sv hdl/*.sv sim/tb_decode_stage.sv
	verilator --binary --timing --assert -f src.f --top-module tb_decode_stage

sim: obj_dir/Vtb_decode_stage
	./obj_dir/Vtb_decode_stage > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "^Simulation PASSED$$" sim.log; then \
	  echo "sim: pass"; \
	else \
	  echo "sim: fail"; \
	  exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
